// File: Makefile
# Verilator build and run for the image preprocessing testbench

TOP := img_preproc_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f hw/*.sv verif/img_preproc_tb.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

# The simulator exit code is not trusted, the log decides
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module img_preproc_top -f vlog.f

clean:
	rm -rf obj_dir sim.log

// File: hw/apb_status_regs.sv
// APB register block with the control register, decoder status and event counters
`default_nettype none

module apb_status_regs (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  psel_i,
    input  wire logic                                  penable_i,
    input  wire logic                                  pwrite_i,
    input  wire logic [img_preproc_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic [31:0]                           pwdata_i,
    input  wire logic                                  idle_i,
    input  wire logic                                  frame_done_i,
    input  wire logic                                  pixel_fire_i,
    input  wire logic                                  err_trunc_i,
    output logic [31:0]                                prdata_o,
    output logic                                       pready_o,
    output logic                                       pslverr_o,
    output logic                                       enable_o,
    output img_preproc_pkg::out_fmt_e                  out_fmt_o
);

    import img_preproc_pkg::*;

    // Counters in the order frames, pixels, errors
    logic [31:0] count_q [3];
    logic [2:0]  count_inc;
    logic [2:0]  count_clr;
    logic        access;
    logic        wr;
    logic        addr_ok;

    // Every access completes in its access phase
    assign pready_o = 1'b1;

    assign access  = psel_i && penable_i;
    assign wr      = access && pwrite_i;
    assign addr_ok = (paddr_i == reg_ctrl_c)   || (paddr_i == reg_status_c) ||
                     (paddr_i == reg_frames_c) || (paddr_i == reg_pixels_c) ||
                     (paddr_i == reg_errors_c);

    assign pslverr_o = access && !addr_ok;

    assign count_inc = {err_trunc_i, pixel_fire_i, frame_done_i};
    assign count_clr = {wr && (paddr_i == reg_errors_c),
                        wr && (paddr_i == reg_pixels_c),
                        wr && (paddr_i == reg_frames_c)};

    always_ff @(posedge clock) begin
        if (reset) begin
            enable_o  <= 1'b0;
            out_fmt_o <= fmt_xy;
        end else if (wr && (paddr_i == reg_ctrl_c)) begin
            enable_o  <= pwdata_i[0];
            out_fmt_o <= out_fmt_e'(pwdata_i[1]);
        end
    end

    // A write clears a counter whatever the data, and a full counter stays full
    for (genvar i = 0; i < 3; i++) begin : g_count
        always_ff @(posedge clock) begin
            if (reset || count_clr[i]) begin
                count_q[i] <= 32'd0;
            end else if (count_inc[i] && (count_q[i] != 32'hFFFF_FFFF)) begin
                count_q[i] <= count_q[i] + 32'd1;
            end
        end
    end

    always_comb begin
        case (paddr_i)
            reg_ctrl_c:   prdata_o = {30'd0, out_fmt_o, enable_o};
            reg_status_c: prdata_o = {31'd0, idle_i};
            reg_frames_c: prdata_o = count_q[0];
            reg_pixels_c: prdata_o = count_q[1];
            reg_errors_c: prdata_o = count_q[2];
            default:      prdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/frame_ctrl.sv
// Frame controller that turns the host word stream into strobed, last-marked payload words
`default_nettype none

module frame_ctrl (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [31:0] in_data_i,
    input  wire logic        in_valid_i,
    input  wire logic        enable_i,
    input  wire logic        word_ready_i,
    output logic             upstream_stall_o,
    output logic             word_valid_o,
    output logic [31:0]      word_data_o,
    output logic [3:0]       word_strb_o,
    output logic             word_last_o,
    output logic             decoder_clear_o
);

    // Bytes still expected in the current frame, zero between frames
    logic [31:0] count_q;
    logic        is_len;
    logic        len_fire;
    logic        word_fire;

    // With no bytes pending the next word is a length word
    assign is_len = (count_q == 32'd0);

    // A length word never waits, payload words wait for the input buffer
    assign upstream_stall_o = !enable_i || (!is_len && !word_ready_i);

    assign len_fire  = in_valid_i && enable_i && is_len;
    assign word_fire = word_valid_o && word_ready_i;

    // A zero length word is a resync request and carries no frame
    assign decoder_clear_o = len_fire && (in_data_i == 32'd0);

    assign word_valid_o = in_valid_i && enable_i && !is_len;
    assign word_data_o  = in_data_i;
    assign word_last_o  = !is_len && (count_q <= 32'd4);

    // Only the final word of a frame can be short, and only in its upper bytes
    always_comb begin
        word_strb_o = 4'b1111;
        if (count_q < 32'd4) begin
            case (count_q[1:0])
                2'd1:    word_strb_o = 4'b0001;
                2'd2:    word_strb_o = 4'b0011;
                2'd3:    word_strb_o = 4'b0111;
                default: word_strb_o = 4'b1111;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count_q <= 32'd0;
        end else if (len_fire) begin
            count_q <= in_data_i;
        end else if (word_fire) begin
            // Saturate so a short final word still lands on zero
            count_q <= (count_q > 32'd4) ? (count_q - 32'd4) : 32'd0;
        end
    end

    // A partial strobe may only appear on the word that closes the frame
    a_short_strb_is_last: assert property (
        @(posedge clock) disable iff (reset)
        (word_valid_o && (word_strb_o != 4'b1111)) |-> word_last_o
    );

endmodule

`default_nettype wire

// File: hw/img_preproc_pkg.sv
// Image preprocessing package with register map, payload structs and output formats
`default_nettype none

package img_preproc_pkg;

    // APB register window is twelve bits of byte address
    localparam int apb_addr_w = 12;

    localparam logic [apb_addr_w-1:0] reg_ctrl_c   = 12'h000;
    localparam logic [apb_addr_w-1:0] reg_status_c = 12'h004;
    localparam logic [apb_addr_w-1:0] reg_frames_c = 12'h008;
    localparam logic [apb_addr_w-1:0] reg_pixels_c = 12'h00C;
    localparam logic [apb_addr_w-1:0] reg_errors_c = 12'h010;

    // Width of the pixel coordinates and of the header width and height fields
    localparam int coord_w = 16;

    // Selects what the output word carries
    // fmt_xy gives x in the upper half and y in the lower half
    // fmt_rgb gives a zero top byte followed by R, G and B
    typedef enum logic {
        fmt_xy  = 1'b0,
        fmt_rgb = 1'b1
    } out_fmt_e;

    // One input word on its way from the frame controller to the decoder
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } in_word_t;

    // One decoded raster pixel on its way to the output formatter
    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [7:0]         r;
        logic [7:0]         g;
        logic [7:0]         b;
    } pixel_t;

endpackage

`default_nettype wire

// File: hw/img_preproc_top.sv
// Image preprocessing front end from host word stream to formatted pixel words
`default_nettype none

module img_preproc_top (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic [31:0]                           in_data_i,
    input  wire logic                                  in_valid_i,
    output logic                                       upstream_stall_o,
    output logic [31:0]                                out_data_o,
    output logic                                       out_valid_o,
    input  wire logic                                  downstream_stall_i,
    input  wire logic                                  psel_i,
    input  wire logic                                  penable_i,
    input  wire logic                                  pwrite_i,
    input  wire logic [img_preproc_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic [31:0]                           pwdata_i,
    output logic [31:0]                                prdata_o,
    output logic                                       pready_o,
    output logic                                       pslverr_o
);

    import img_preproc_pkg::*;

    logic        enable;
    out_fmt_e    out_fmt;
    logic        word_valid;
    logic        word_ready;
    logic [31:0] word_data;
    logic [3:0]  word_strb;
    logic        word_last;
    logic        decoder_clear;
    in_word_t    in_word;
    in_word_t    dec_word;
    logic        dec_word_valid;
    logic        dec_word_ready;
    pixel_t      pix;
    pixel_t      out_pix;
    logic        pix_valid;
    logic        pix_ready;
    logic        frame_done;
    logic        err_trunc;
    logic        idle;

    frame_ctrl u_frame_ctrl (
        .clock            (clock),
        .reset            (reset),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .enable_i         (enable),
        .word_ready_i     (word_ready),
        .upstream_stall_o (upstream_stall_o),
        .word_valid_o     (word_valid),
        .word_data_o      (word_data),
        .word_strb_o      (word_strb),
        .word_last_o      (word_last),
        .decoder_clear_o  (decoder_clear)
    );

    assign in_word = '{data: word_data, strb: word_strb, last: word_last};

    // A resync flushes words still waiting for the decoder, finished pixels are kept
    stream_skid_buffer #(.payload_t(in_word_t)) u_in_buf (
        .clock   (clock),
        .reset   (reset),
        .clear_i (decoder_clear),
        .valid_i (word_valid),
        .data_i  (in_word),
        .ready_o (word_ready),
        .ready_i (dec_word_ready),
        .valid_o (dec_word_valid),
        .data_o  (dec_word)
    );

    raw_image_decoder u_decoder (
        .clock         (clock),
        .reset         (reset),
        .clear_i       (decoder_clear),
        .word_valid_i  (dec_word_valid),
        .word_data_i   (dec_word.data),
        .word_strb_i   (dec_word.strb),
        .word_last_i   (dec_word.last),
        .pixel_ready_i (pix_ready),
        .word_ready_o  (dec_word_ready),
        .pixel_valid_o (pix_valid),
        .pixel_x_o     (pix.x),
        .pixel_y_o     (pix.y),
        .pixel_r_o     (pix.r),
        .pixel_g_o     (pix.g),
        .pixel_b_o     (pix.b),
        .frame_done_o  (frame_done),
        .err_trunc_o   (err_trunc),
        .idle_o        (idle)
    );

    stream_skid_buffer #(.payload_t(pixel_t)) u_out_buf (
        .clock   (clock),
        .reset   (reset),
        .clear_i (1'b0),
        .valid_i (pix_valid),
        .data_i  (pix),
        .ready_o (pix_ready),
        .ready_i (!downstream_stall_i),
        .valid_o (out_valid_o),
        .data_o  (out_pix)
    );

    apb_status_regs u_regs (
        .clock        (clock),
        .reset        (reset),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .idle_i       (idle),
        .frame_done_i (frame_done),
        .pixel_fire_i (pix_valid && pix_ready),
        .err_trunc_i  (err_trunc),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .enable_o     (enable),
        .out_fmt_o    (out_fmt)
    );

    // The output word is built from the buffered pixel, so it holds while stalled
    assign out_data_o = (out_fmt == fmt_xy) ? {out_pix.x, out_pix.y}
                                            : {8'h00, out_pix.r, out_pix.g, out_pix.b};

endmodule

`default_nettype wire

// File: hw/raw_image_decoder.sv
// Raw image decoder that parses the width/height header and emits raster RGB pixels
`default_nettype none

module raw_image_decoder (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        clear_i,
    input  wire logic                        word_valid_i,
    input  wire logic [31:0]                 word_data_i,
    input  wire logic [3:0]                  word_strb_i,
    input  wire logic                        word_last_i,
    input  wire logic                        pixel_ready_i,
    output logic                             word_ready_o,
    output logic                             pixel_valid_o,
    output logic [img_preproc_pkg::coord_w-1:0] pixel_x_o,
    output logic [img_preproc_pkg::coord_w-1:0] pixel_y_o,
    output logic [7:0]                       pixel_r_o,
    output logic [7:0]                       pixel_g_o,
    output logic [7:0]                       pixel_b_o,
    output logic                             frame_done_o,
    output logic                             err_trunc_o,
    output logic                             idle_o
);

    import img_preproc_pkg::*;

    // Byte queue with the oldest byte in bits 7:0, holding at most six bytes
    logic [47:0]        buf_q;
    logic [2:0]         cnt_q;
    logic               hdr_done_q;
    logic               ending_q;
    logic [coord_w-1:0] width_q;
    logic [coord_w-1:0] height_q;
    logic [coord_w-1:0] x_q;
    logic [coord_w-1:0] y_q;

    logic        word_fire;
    logic        pixel_fire;
    logic        hdr_take;
    logic        all_done;
    logic        frame_end;
    logic [2:0]  take;
    logic [2:0]  rem_cnt;
    logic [47:0] rem_buf;
    logic [47:0] keep_mask;
    logic [31:0] in_bytes;
    logic [2:0]  n_in;
    logic [47:0] buf_d;
    logic [2:0]  cnt_d;

    // Every pixel of the frame has been sent, so further bytes are dropped
    assign all_done = hdr_done_q && ((y_q >= height_q) || (width_q == '0));

    // The header is taken in one step once all four of its bytes are queued
    assign hdr_take = !hdr_done_q && (cnt_q >= 3'd4);

    assign pixel_valid_o = hdr_done_q && !all_done && (cnt_q >= 3'd3);
    assign pixel_fire    = pixel_valid_o && pixel_ready_i;
    assign pixel_x_o     = x_q;
    assign pixel_y_o     = y_q;
    assign pixel_r_o     = buf_q[7:0];
    assign pixel_g_o     = buf_q[15:8];
    assign pixel_b_o     = buf_q[23:16];

    // A new word fits only while two bytes or fewer are queued
    assign word_ready_o = !ending_q && (cnt_q <= 3'd2);
    assign word_fire    = word_valid_i && word_ready_o;

    // After the last word the frame ends when the queue can yield nothing more
    assign frame_end = ending_q &&
        (hdr_done_q ? (all_done || (cnt_q < 3'd3)) : (cnt_q < 3'd4));

    assign frame_done_o = frame_end;
    assign err_trunc_o  = frame_end && !all_done;
    assign idle_o       = !hdr_done_q && !ending_q && (cnt_q == 3'd0);

    // Bytes leaving the queue this cycle
    assign take = hdr_take   ? 3'd4 :
                  pixel_fire ? 3'd3 :
                  all_done   ? cnt_q : 3'd0;

    assign rem_cnt   = cnt_q - take;
    assign rem_buf   = buf_q >> {take, 3'b000};
    assign keep_mask = ~({48{1'b1}} << {rem_cnt, 3'b000});

    // Strobes are contiguous from byte 0, so masking and counting is enough
    always_comb begin
        in_bytes = 32'd0;
        n_in     = 3'd0;
        for (int i = 0; i < 4; i++) begin
            if (word_strb_i[i]) begin
                in_bytes[8*i +: 8] = word_data_i[8*i +: 8];
                n_in               = n_in + 3'd1;
            end
        end
    end

    always_comb begin
        buf_d = rem_buf & keep_mask;
        cnt_d = rem_cnt;
        if (word_fire && !all_done) begin
            buf_d = buf_d | ({16'd0, in_bytes} << {rem_cnt, 3'b000});
            cnt_d = rem_cnt + n_in;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i || frame_end) begin
            cnt_q      <= 3'd0;
            hdr_done_q <= 1'b0;
            ending_q   <= 1'b0;
            x_q        <= '0;
            y_q        <= '0;
        end else begin
            cnt_q <= cnt_d;
            if (hdr_take) begin
                hdr_done_q <= 1'b1;
            end
            if (word_fire && word_last_i) begin
                ending_q <= 1'b1;
            end
            // Raster order with x running fastest
            if (pixel_fire) begin
                if (x_q == width_q - 1'b1) begin
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        buf_q <= buf_d;
        // Header is width then height, both little endian
        if (hdr_take) begin
            width_q  <= buf_q[15:0];
            height_q <= buf_q[31:16];
        end
    end

    a_x_in_range: assert property (
        @(posedge clock) disable iff (reset)
        pixel_valid_o |-> (pixel_x_o < width_q)
    );

endmodule

`default_nettype wire

// File: hw/stream_skid_buffer.sv
// Two-entry skid buffer that registers both directions of a valid/ready stream
`default_nettype none

module stream_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic clear_i,
    input  wire logic valid_i,
    input  payload_t  data_i,
    output logic      ready_o,
    input  wire logic ready_i,
    output logic      valid_o,
    output payload_t  data_o
);

    // The output register feeds the consumer, the skid register catches
    // the one item that arrives while the consumer stalls
    logic     skid_valid_q;
    payload_t skid_data_q;
    logic     in_fire;
    logic     load;

    // Ready comes straight from a flop so there is no path from ready_i to ready_o
    assign ready_o = !skid_valid_q;
    assign in_fire = valid_i && !skid_valid_q;

    // The output register may be refilled when it is empty or being drained
    assign load = ready_i || !valid_o;

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            valid_o      <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (load) begin
            valid_o      <= skid_valid_q || in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            // The older skid item always leaves first
            data_o <= skid_valid_q ? skid_data_q : data_i;
        end else if (in_fire) begin
            skid_data_q <= data_i;
        end
    end

    // A stalled item holds its value until the consumer takes it
    a_hold_when_stalled: assert property (
        @(posedge clock) disable iff (reset)
        (valid_o && !ready_i && !clear_i) |=> (valid_o && $stable(data_o))
    );

endmodule

`default_nettype wire

// File: verif/img_preproc_tb.sv
// Self-checking testbench for the image preprocessing front end, driven from a vectors file
`default_nettype none

module img_preproc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import img_preproc_pkg::*;

    // Each record is a tag word followed by a value word
    localparam int mem_words    = 512;
    localparam int reset_cycles = 3;

    logic                  clock              = 1'b0;
    logic                  reset              = 1'b1;
    logic [31:0]           in_data_i          = 32'd0;
    logic                  in_valid_i         = 1'b0;
    logic                  downstream_stall_i = 1'b0;
    logic                  psel_i             = 1'b0;
    logic                  penable_i          = 1'b0;
    logic                  pwrite_i           = 1'b0;
    logic [apb_addr_w-1:0] paddr_i            = '0;
    logic [31:0]           pwdata_i           = 32'd0;
    logic                  upstream_stall_o;
    logic [31:0]           out_data_o;
    logic                  out_valid_o;
    logic [31:0]           prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;

    logic [31:0] vec_mem [mem_words];
    logic [31:0] stream_q [$];
    logic [31:0] exp_q [$];
    logic        word_taken  = 1'b0;
    logic        stall_on    = 1'b0;
    logic [31:0] rng_state   = 32'h8afb_d703;
    int          checks      = 0;
    int          errors      = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          num_records = 0;

    img_preproc_top dut (
        .clock              (clock),
        .reset              (reset),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i),
        .psel_i             (psel_i),
        .penable_i          (penable_i),
        .pwrite_i           (pwrite_i),
        .paddr_i            (paddr_i),
        .pwdata_i           (pwdata_i),
        .prdata_o           (prdata_o),
        .pready_o           (pready_o),
        .pslverr_o          (pslverr_o)
    );

    always #20 clock = !clock;

    // Classic 13/17/5 xorshift step
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Sampling at the falling edge sees the values that the next rising edge will act on
    always @(negedge clock) begin
        word_taken = in_valid_i && !upstream_stall_o && !reset;
        if (!reset && out_valid_o && !downstream_stall_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output word %h arrived at %0t when no word was expected",
                         out_data_o, $time);
            end else begin
                check_value("out_data_o", out_data_o, exp_q.pop_front());
            end
        end
    end

    // Stream driver, the front word stays on the bus until the DUT takes it
    always @(posedge clock) begin
        #5;
        if (word_taken && stream_q.size() != 0) begin
            stream_q.delete(0);
        end
        in_valid_i = (stream_q.size() != 0);
        in_data_i  = (stream_q.size() != 0) ? stream_q[0] : 32'd0;
        // Roughly three cycles in eight are stalled once stalls are switched on
        rng_state          = xorshift(rng_state);
        downstream_stall_i = stall_on && (rng_state[2:0] < 3'd3);
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Setup phase then access phase, read data is taken in the access phase
    task automatic apb_access(input logic write, input logic [apb_addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clock);
        #5;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clock);
        #5;
        penable_i = 1'b1;
        @(negedge clock);
        rdata = prdata_o;
        err   = pslverr_o;
        check_value("pready_o", 32'(pready_o), 32'd1);
        @(posedge clock);
        #5;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Waits until every queued word is sent and checked, then polls STATUS for idle
    task automatic wait_idle();
        logic [31:0] rdata;
        logic        err;
        while (stream_q.size() != 0 || exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        rdata = 32'd0;
        while (rdata[0] !== 1'b1) begin
            apb_access(1'b0, reg_status_c, 32'd0, rdata, err);
        end
    endtask

    // With enable clear the pending word must sit unaccepted, then it is dropped
    task automatic hold_check(input int n);
        repeat (n) begin
            @(negedge clock);
            check_value("upstream_stall_o", 32'(upstream_stall_o), 32'd1);
        end
        stream_q.delete();
    endtask

    initial begin
        logic [31:0] tag;
        logic [31:0] value;
        logic [31:0] rdata;
        logic        err;
        int          test_errors;

        $readmemh("verif/img_preproc_vectors.txt", vec_mem);
        while (2 * num_records < mem_words && vec_mem[2 * num_records][15:12] != 4'h0) begin
            num_records++;
        end
        cycle_limit = 20 * num_records + reset_cycles;

        repeat (reset_cycles) @(posedge clock);
        #5;
        reset = 1'b0;
        @(negedge clock);
        check_value("upstream_stall_o", 32'(upstream_stall_o), 32'd1);
        check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        check_value("pslverr_o", 32'(pslverr_o), 32'd0);
        $display("test 0: %s", (errors == 0) ? "ok" : "errors found");
        test_errors = errors;

        for (int idx = 0; idx < num_records; idx++) begin
            tag   = vec_mem[2 * idx];
            value = vec_mem[2 * idx + 1];
            case (tag[15:12])
                4'h1: begin
                    wait_idle();
                    apb_access(1'b1, tag[11:0], value, rdata, err);
                    check_value("pslverr_o", 32'(err), 32'd0);
                end
                4'h2, 4'hA: begin
                    wait_idle();
                    apb_access(1'b0, tag[11:0], 32'd0, rdata, err);
                    check_value("prdata_o", rdata, value);
                    check_value("pslverr_o", 32'(err), (tag[15:12] == 4'hA) ? 32'd1 : 32'd0);
                end
                4'h3: stream_q.push_back(value);
                4'h4: exp_q.push_back(value);
                4'h5: stall_on = value[0];
                4'h6: hold_check(int'(value));
                4'h7: begin
                    wait_idle();
                    $display("test %0d: %s", value, (errors == test_errors) ? "ok" : "errors found");
                    test_errors = errors;
                end
                default: begin
                    errors++;
                    $display("Record %0d has an unknown tag %h", idx, tag);
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/img_preproc_vectors.txt
// Records are tag and value, tag bits 15:12 give the operation and bits 11:0 the APB address
// 1 write, 2 read expecting value, A read expecting pslverr, 3 stream word, 4 expected output,
// 5 stall mode, 6 hold check cycles, 7 end of test, 0 end of vectors
// Test 1, 2x2 frame with the xy output format
1000 00000001
3000 00000010 3000 00020002 3000 21131211 3000 32312322 3000 43424133
4000 00000000 4000 00010000 4000 00000001 4000 00010001
7000 00000001
// Test 2, the same frame with the rgb output format
1000 00000003
3000 00000010 3000 00020002 3000 21131211 3000 32312322 3000 43424133
4000 00111213 4000 00212223 4000 00313233 4000 00414243
7000 00000002
// Test 3, 3x1 frame of 13 bytes whose last word carries junk above its one strobed byte
3000 0000000D 3000 00010003 3000 61535251 3000 72716362 3000 DDCCBB73
4000 00515253 4000 00616263 4000 00717273
200C 0000000B
7000 00000003
// Test 4, three frames back to back under random downstream stalls
1000 00000001
5000 00000001
3000 0000000D 3000 00030001 3000 84838281 3000 88878685 3000 00000089
4000 00000000 4000 00000001 4000 00000002
3000 00000010 3000 00010004 3000 93929190 3000 97969594 3000 9B9A9998
4000 00000000 4000 00010000 4000 00020000 4000 00030000
3000 00000010 3000 00020002 3000 21131211 3000 32312322 3000 43424133
4000 00000000 4000 00010000 4000 00000001 4000 00010001
7000 00000004
// Test 5, counters, a zero length resync and a truncated 2x2 frame
2008 00000006 200C 00000016 2010 00000000
1008 00000000 2008 00000000 100C 00000000 200C 00000000
3000 00000000
3000 00000010 3000 00020002 3000 21131211 3000 32312322 3000 43424133
4000 00000000 4000 00010000 4000 00000001 4000 00010001
3000 0000000A 3000 00020002 3000 21131211 3000 00002322
4000 00000000 4000 00010000
2008 00000002 200C 00000006 2010 00000001
7000 00000005
// Test 6, enable clear holds the stream and undefined addresses return pslverr
1000 00000000
3000 00000010
6000 00000010
A014 00000000 A100 00000000
2000 00000000 2004 00000001
7000 00000006
0000 00000000

// File: vlog.f
hw/img_preproc_pkg.sv
hw/frame_ctrl.sv
hw/stream_skid_buffer.sv
hw/raw_image_decoder.sv
hw/apb_status_regs.sv
hw/img_preproc_top.sv
verif/img_preproc_tb.sv
